//--- Makefile
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module riscv_tb

sim:
	verilator --binary --timing --assert -f tb.f --top-module riscv_tb \
		--Mdir $(OBJ_DIR) -o Vriscv_tb
	./$(OBJ_DIR)/Vriscv_tb | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src/riscv_alu.sv
`timescale 1ns/1ps

module riscv_alu import riscv_pkg::*; #(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  alu_op_e         i_op,
  input  logic [XLEN-1:0] i_a,
  input  logic [XLEN-1:0] i_b,
  output logic [XLEN-1:0] o_y
);

  localparam int SHW = $clog2(XLEN);

  logic [SHW-1:0] shamt;
  logic           lt_s;
  logic           lt_u;

  assign shamt = i_b[SHW-1:0];  // upper bits ignored
  assign lt_s  = $signed(i_a) < $signed(i_b);
  assign lt_u  = i_a < i_b;

  always_comb begin
    case (i_op)
      ALU_ADD:  o_y = i_a + i_b;
      ALU_SUB:  o_y = i_a - i_b;
      ALU_SLL:  o_y = i_a << shamt;
      ALU_SLT:  o_y = XLEN'(lt_s);
      ALU_SLTU: o_y = XLEN'(lt_u);
      ALU_XOR:  o_y = i_a ^ i_b;
      ALU_SRL:  o_y = i_a >> shamt;
      ALU_SRA:  o_y = $unsigned($signed(i_a) >>> shamt);
      ALU_OR:   o_y = i_a | i_b;
      ALU_AND:  o_y = i_a & i_b;
      default:  o_y = '0;  // unused encodings
    endcase
  end

endmodule

//--- src/riscv_decode.sv
`timescale 1ns/1ps

module riscv_decode import riscv_pkg::*; #(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  logic     i_riscv_clk,
  input  logic     i_arst_n,
  input  logic     i_inst_valid,
  input  rv_inst_u i_inst,
  input  wb_s      i_wb,
  output id_ex_s   o_id_ex
);

  logic [XLEN-1:0] rf_rs1_data;
  logic [XLEN-1:0] rf_rs2_data;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] imm;
  logic            known_opc;
  logic            is_op;
  logic            is_op_imm;
  logic            is_lui;
  logic            f7_5;
  alu_op_e         alu_op;

  riscv_regfile #(.XLEN(XLEN)) u_riscv_regfile (
    .i_riscv_clk (i_riscv_clk),
    .i_arst_n    (i_arst_n),
    .i_wr        (i_wb),
    .i_rs1_addr  (i_inst.r.rs1),
    .i_rs2_addr  (i_inst.r.rs2),
    .o_rs1_data  (rf_rs1_data),
    .o_rs2_data  (rf_rs2_data)
  );

  assign is_op     = (i_inst.r.opcode == OPC_OP);
  assign is_op_imm = (i_inst.r.opcode == OPC_OP_IMM);
  assign is_lui    = (i_inst.r.opcode == OPC_LUI);
  assign known_opc = is_op | is_op_imm | is_lui;
  assign f7_5      = i_inst.r.funct7[5];  // imm12[10] in the I view

  always_comb begin
    case (i_inst.r.funct3)
      3'b000:  alu_op = (is_op && f7_5) ? ALU_SUB : ALU_ADD;  // no subi
      3'b001:  alu_op = ALU_SLL;
      3'b010:  alu_op = ALU_SLT;
      3'b011:  alu_op = ALU_SLTU;
      3'b100:  alu_op = ALU_XOR;
      3'b101:  alu_op = f7_5 ? ALU_SRA : ALU_SRL;  // srai too
      3'b110:  alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
  end

  // sign extended in both cases
  assign imm = is_lui ? XLEN'(signed'({i_inst.u.imm20, 12'h000}))
                      : XLEN'(signed'(i_inst.i.imm12));

  // write landing this cycle bypasses the array
  assign rs1_val = (i_wb.valid && i_wb.rd == i_inst.r.rs1) ? i_wb.data : rf_rs1_data;
  assign rs2_val = (i_wb.valid && i_wb.rd == i_inst.r.rs2) ? i_wb.data : rf_rs2_data;

  always_ff @(posedge i_riscv_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_id_ex <= '0;
    end else begin
      o_id_ex.valid   <= i_inst_valid && known_opc && (i_inst.r.rd != 5'd0);
      o_id_ex.rd      <= i_inst.r.rd;
      o_id_ex.rs1     <= i_inst.r.rs1;
      o_id_ex.rs2     <= i_inst.r.rs2;
      o_id_ex.op1     <= rs1_val;
      o_id_ex.op2_reg <= rs2_val;
      o_id_ex.imm     <= imm;
      o_id_ex.use_imm <= is_op_imm;
      o_id_ex.is_lui  <= is_lui;
      o_id_ex.alu_op  <= is_lui ? ALU_ADD : alu_op;
    end
  end

  // x0 stays zero through array and bypass
  a_x0_rs1: assert property (@(posedge i_riscv_clk) disable iff (!i_arst_n)
    (i_inst.r.rs1 == 5'd0) |-> (rs1_val == '0));
  a_x0_rs2: assert property (@(posedge i_riscv_clk) disable iff (!i_arst_n)
    (i_inst.r.rs2 == 5'd0) |-> (rs2_val == '0));

endmodule

//--- src/riscv_execute.sv
`timescale 1ns/1ps

module riscv_execute import riscv_pkg::*; #(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  logic   i_riscv_clk,
  input  logic   i_arst_n,
  input  id_ex_s i_id_ex,
  input  wb_s    i_fwd,
  output ex_rs_s o_ex_rs
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b_reg;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_y;

  // previous instruction is still in the result stage
  assign op_a     = (i_fwd.valid && i_fwd.rd == i_id_ex.rs1) ? i_fwd.data : i_id_ex.op1;
  assign op_b_reg = (i_fwd.valid && i_fwd.rd == i_id_ex.rs2) ? i_fwd.data : i_id_ex.op2_reg;
  assign op_b     = i_id_ex.use_imm ? i_id_ex.imm : op_b_reg;

  riscv_alu #(.XLEN(XLEN)) u_riscv_alu (
    .i_op (i_id_ex.alu_op),
    .i_a  (op_a),
    .i_b  (op_b),
    .o_y  (alu_y)
  );

  always_ff @(posedge i_riscv_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ex_rs <= '0;
    end else begin
      o_ex_rs.valid   <= i_id_ex.valid;
      o_ex_rs.rd      <= i_id_ex.rd;
      o_ex_rs.alu_res <= alu_y;
      o_ex_rs.imm     <= i_id_ex.imm;  // lui value
      o_ex_rs.is_lui  <= i_id_ex.is_lui;
    end
  end

  a_valid_known: assert property (@(posedge i_riscv_clk) disable iff (!i_arst_n)
    !$isunknown(o_ex_rs.valid));

endmodule

//--- src/riscv_int_pipe.sv
`timescale 1ns/1ps

module riscv_int_pipe import riscv_pkg::*; #(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  logic        i_riscv_clk,
  input  logic        i_arst_n,
  input  logic        i_inst_valid,
  input  rv_inst_u    i_inst,
  output wb_s         o_wb,
  output logic [31:0] o_retired
);

  id_ex_s id_ex;
  ex_rs_s ex_rs;

  riscv_decode #(.XLEN(XLEN)) u_riscv_decode (
    .i_riscv_clk  (i_riscv_clk),
    .i_arst_n     (i_arst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_wb         (o_wb),  // register write
    .o_id_ex      (id_ex)
  );

  riscv_execute #(.XLEN(XLEN)) u_riscv_execute (
    .i_riscv_clk (i_riscv_clk),
    .i_arst_n    (i_arst_n),
    .i_id_ex     (id_ex),
    .i_fwd       (o_wb),  // forwarding source
    .o_ex_rs     (ex_rs)
  );

  riscv_result #(.XLEN(XLEN)) u_riscv_result (
    .i_riscv_clk (i_riscv_clk),
    .i_arst_n    (i_arst_n),
    .i_ex_rs     (ex_rs),
    .o_wb        (o_wb),
    .o_retired   (o_retired)
  );

  // stage structs are sized by the package width
  a_xlen_match: assert property (@(posedge i_riscv_clk) XLEN == XLEN_DEFAULT);

endmodule

//--- src/riscv_pkg.sv
package riscv_pkg;

  parameter int XLEN_DEFAULT = 32;

  // opcodes handled by the decoder
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // one instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [6:0]  funct7;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } rv_inst_u;

  // register write, also the external report
  typedef struct packed {
    logic                    valid;
    logic [4:0]              rd;
    logic [XLEN_DEFAULT-1:0] data;
  } wb_s;

  typedef struct packed {
    logic                    valid;
    logic [4:0]              rd;
    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic [XLEN_DEFAULT-1:0] op1;
    logic [XLEN_DEFAULT-1:0] op2_reg;
    logic [XLEN_DEFAULT-1:0] imm;
    logic                    use_imm;
    logic                    is_lui;
    alu_op_e                 alu_op;
  } id_ex_s;

  typedef struct packed {
    logic                    valid;
    logic [4:0]              rd;
    logic [XLEN_DEFAULT-1:0] alu_res;
    logic [XLEN_DEFAULT-1:0] imm;
    logic                    is_lui;
  } ex_rs_s;

endpackage

//--- src/riscv_regfile.sv
`timescale 1ns/1ps

module riscv_regfile import riscv_pkg::*; #(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  logic            i_riscv_clk,
  input  logic            i_arst_n,
  input  wb_s             i_wr,
  input  logic [4:0]      i_rs1_addr,
  input  logic [4:0]      i_rs2_addr,
  output logic [XLEN-1:0] o_rs1_data,
  output logic [XLEN-1:0] o_rs2_data
);

  logic [XLEN-1:0] regs [31:1];  // x0 has no storage

  always_ff @(posedge i_riscv_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.valid && i_wr.rd != 5'd0) begin
      regs[i_wr.rd] <= i_wr.data;
    end
  end

  // hardwired zero for x0
  assign o_rs1_data = (i_rs1_addr == 5'd0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == 5'd0) ? '0 : regs[i_rs2_addr];

endmodule

//--- src/riscv_result.sv
`timescale 1ns/1ps

module riscv_result import riscv_pkg::*; #(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  logic        i_riscv_clk,
  input  logic        i_arst_n,
  input  ex_rs_s      i_ex_rs,
  output wb_s         o_wb,
  output logic [31:0] o_retired
);

  logic [XLEN-1:0] wb_data;

  assign wb_data    = i_ex_rs.is_lui ? i_ex_rs.imm : i_ex_rs.alu_res;
  assign o_wb.valid = i_ex_rs.valid;
  assign o_wb.rd    = i_ex_rs.rd;
  assign o_wb.data  = wb_data;

  always_ff @(posedge i_riscv_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_retired <= '0;
    end else if (o_wb.valid) begin
      o_retired <= o_retired + 32'd1;  // wraps
    end
  end

  // decode filters x0 two stages back
  a_no_x0_write: assert property (@(posedge i_riscv_clk) disable iff (!i_arst_n)
    o_wb.valid |-> (o_wb.rd != 5'd0));

endmodule

//--- tb.f
src/riscv_pkg.sv
src/riscv_regfile.sv
src/riscv_decode.sv
src/riscv_alu.sv
src/riscv_execute.sv
src/riscv_result.sv
src/riscv_int_pipe.sv
test/tb_clkgen.sv
test/riscv_tb.sv

//--- test/riscv_tb.sv
`timescale 1ns/1ps

module riscv_tb import riscv_pkg::*;;
  localparam int N_RR = 200;
  localparam int N_IMM = 200;
  localparam int N_FWD = 100;
  localparam int N_NOW = 60;
  localparam int DRAIN = 4;
  localparam int N_SLOTS = N_RR + N_IMM + N_FWD + N_NOW + 5 * DRAIN + 2;
  localparam real PERIOD = 4.0;

  typedef struct packed {
    logic [31:0] due;  // negedge count when the report shows
    logic [4:0]  rd;
    logic [31:0] data;
  } exp_s;

  logic clk;
  logic i_arst_n;
  logic i_inst_valid;
  rv_inst_u i_inst;
  wb_s o_wb;
  logic [31:0] o_retired;
  logic [15:0] lfsr = 16'd15;
  logic [31:0] regs [32];
  exp_s exp_q[$];
  int ncyc = 0;
  int errors = 0;
  int test_errors = 0;
  int n_expected = 0;
  logic [4:0] prev1 = 5'd1;  // rd one and two places back
  logic [4:0] prev2 = 5'd2;
  bit checking = 0;
  string cur_test;

  tb_clkgen #(.PERIOD(PERIOD)) u_tb_clkgen (.o_clk(clk));

  riscv_int_pipe #(.XLEN(XLEN_DEFAULT)) riscv_int_pipe_i (
    .i_riscv_clk  (clk),
    .i_arst_n     (i_arst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .o_wb         (o_wb),
    .o_retired    (o_retired)
  );

  // taps 16 14 13 11 and one step per bit
  function automatic logic [31:0] take(int n);
    logic [31:0] v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] model_alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];  // sign bit fills in
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // reference result in program order
  function automatic void model(rv_inst_u in);
    logic [31:0] res;
    logic [31:0] a;
    a = regs[in.r.rs1];
    if (in.r.opcode == OPC_OP)
      res = model_alu(in.r.funct3, in.r.funct7[5], a, regs[in.r.rs2]);
    else if (in.r.opcode == OPC_OP_IMM)
      res = model_alu(in.i.funct3, in.i.funct3 == 3'd5 && in.i.imm12[10], a,
                      {{20{in.i.imm12[11]}}, in.i.imm12});
    else if (in.r.opcode == OPC_LUI) res = {in.u.imm20, 12'h000};
    else return;
    if (in.r.rd == 5'd0) return;
    regs[in.r.rd] = res;
    exp_q.push_back('{due: ncyc + 3, rd: in.r.rd, data: res});
    n_expected++;
  endfunction

  task automatic issue(rv_inst_u in, logic v);
    @(posedge clk);
    i_inst <= in;
    i_inst_valid <= v;
    if (v) model(in);
  endtask

  function automatic rv_inst_u gen_rr();
    rv_inst_u in;
    in.r.opcode = OPC_OP;
    in.r.funct3 = 3'(take(3));
    in.r.funct7 = (in.r.funct3 == 3'd0 || in.r.funct3 == 3'd5) ?
                  {1'b0, 1'(take(1)), 5'd0} : 7'd0;
    in.r.rs1 = 5'(take(5));
    in.r.rs2 = 5'(take(5));
    in.r.rd = 5'(take(5));
    return in;
  endfunction

  function automatic rv_inst_u gen_imm();
    rv_inst_u in;
    in.i.opcode = OPC_OP_IMM;
    in.i.funct3 = 3'(take(3));
    in.i.imm12 = 12'(take(12));
    if (in.i.funct3 == 3'd1) in.i.imm12[11:5] = 7'd0;
    if (in.i.funct3 == 3'd5) in.i.imm12[11:5] = {1'b0, 1'(take(1)), 5'd0};  // srai or srli
    in.i.rs1 = 5'(take(5));
    in.i.rd = 5'(take(5));
    if (take(2) == 0) begin
      in.u.opcode = OPC_LUI;
      in.u.imm20 = 20'(take(20));
    end
    return in;
  endfunction

  task automatic end_test();
    repeat (DRAIN) issue('0, 1'b0);
    @(negedge clk);
    #(PERIOD / 4.0);  // checker of this edge is done
    $display("test %s: %s (%0d errors)", cur_test, errors == test_errors ? "pass" : "fail",
             errors - test_errors);
    test_errors = errors;
  endtask

  // report checker samples at the falling edge
  always @(negedge clk) begin
    ncyc++;
    if (checking) begin
      if (exp_q.size() > 0 && exp_q[0].due == ncyc) begin
        assert (o_wb.valid) else begin
          $display("%s: expected report for x%0d is missing", cur_test, exp_q[0].rd);
          errors++;
        end
        assert (!o_wb.valid || {o_wb.rd, o_wb.data} == {exp_q[0].rd, exp_q[0].data}) else begin
          $display("FAIL %s: expected x%0d=%h actual x%0d=%h", cur_test, exp_q[0].rd,
                   exp_q[0].data, o_wb.rd, o_wb.data);
          errors++;
        end
        void'(exp_q.pop_front());
      end else begin
        assert (!o_wb.valid) else begin
          $display("%s: unexpected report x%0d=%h", cur_test, o_wb.rd, o_wb.data);
          errors++;
        end
      end
    end
  end

  initial begin
    #((N_SLOTS + 20) * PERIOD);
    $display("watchdog timeout, simulation did not finish");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rv_inst_u in;
    int sel;
    i_arst_n = 1'b0;
    i_inst_valid = 1'b0;
    i_inst = '0;
    foreach (regs[r]) regs[r] = '0;
    repeat (2) @(posedge clk);
    i_arst_n <= 1'b1;
    cur_test = "reset";
    @(negedge clk);
    assert (!o_wb.valid && o_retired == 32'd0) else begin
      $display("FAIL reset: expected valid=0 retired=0 actual valid=%b retired=%0d",
               o_wb.valid, o_retired);
      errors++;
    end
    checking = 1;
    end_test();
    cur_test = "reg_reg";
    repeat (N_RR) issue(gen_rr(), 1'b1);
    end_test();
    cur_test = "imm_lui";
    repeat (N_IMM) issue(gen_imm(), 1'b1);
    end_test();
    cur_test = "forwarding";
    repeat (N_FWD) begin
      in = take(1) ? gen_rr() : gen_imm();
      in.r.rs1 = take(1) ? prev1 : prev2;
      in.r.rs2 = take(1) ? prev1 : prev2;
      in.r.rd = 5'(take(5));
      if (in.r.rd == 5'd0) in.r.rd = 5'd7;
      prev2 = prev1;
      prev1 = in.r.rd;
      issue(in, 1'b1);
    end
    end_test();
    cur_test = "no_write";
    repeat (N_NOW) begin
      sel = take(2);
      in = gen_rr();
      if (sel == 0) begin
        in.r.opcode = 7'(take(7));
        if (in.r.opcode inside {OPC_OP, OPC_OP_IMM, OPC_LUI}) in.r.opcode = 7'b1111111;
      end else if (sel == 1) begin
        in.r.rd = 5'd0;
      end
      issue(in, sel != 2);  // idle slot carries a live-looking word
    end
    end_test();
    assert (o_retired == n_expected) else begin
      $display("FAIL retired: expected %0d actual %0d", n_expected, o_retired);
      errors++;
    end
    $display("checks done: %0d expected reports, %0d errors", n_expected, errors);
    if (errors == 0) $display("ALL CHECKS PASSED");
    else $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- test/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter real PERIOD = 4.0
) (
  output logic o_clk
);

  initial o_clk = 1'b0;
  always #(PERIOD / 2.0) o_clk = ~o_clk;

endmodule
